// ==== common/fetch_defines.svh ====
// fetch subsystem constants
// reset vector, NOP word, jump opcode, fault tags, memory size and latency
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// counter value after reset
`define FETCH_RESET_VEC 32'h0000_0100

// NOP word, opcode and payload halves
`define FETCH_NOP_OPC 6'b000101
`define FETCH_NOP_IMM 26'h041_0000

// unconditional jump opcode
`define FETCH_JUMP_OPC 6'b000000

// fault tags on icpu_tag
// translation miss, page fault, bus error
`define FETCH_ITAG_TE 4'hd
`define FETCH_ITAG_PE 4'hc
`define FETCH_ITAG_BE 4'hb

// instruction memory, words and request-to-answer cycles
`define FETCH_MEM_WORDS 256
`define FETCH_MEM_LAT 2

`endif

// ==== common/fetch_pkg.sv ====
// shared types of the fetch subsystem
// insn_t, one instruction word with a raw view and a jump view
package fetch_pkg;

	// jump view
	// opcode on top, signed word displacement below
	typedef struct packed {
		logic [5:0]         opc;
		logic signed [25:0] disp;
	} insn_jmp_t;

	// same 32 bits, read either way
	typedef union packed {
		logic [31:0] raw;
		insn_jmp_t   jmp;
	} insn_t;

endpackage

// ==== fetch/fetch_genpc.sv ====
// fetch address generator
// request strobe, flush redirect, jump follow, refetch hold
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_genpc (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             if_freeze_i,
	input  logic             if_flushpipe_i,
	input  logic [31:0]      flush_target_i,
	input  fetch_pkg::insn_t if_insn_i,
	input  logic [31:0]      if_pc_i,
	input  logic             if_stall_i,
	input  logic             genpc_refetch_i,
	input  logic             icpu_err_i,
	output logic [31:0]      req_adr_o,
	output logic             req_stb_o
);

	logic [31:0] pc_q;
	logic        stb_q;
	logic        refetch_q;
	logic        accept;
	logic        is_jump;
	logic [31:0] jump_off;
	logic [31:0] pc_next;

	// word present and pipeline running
	assign accept = !if_stall_i && !if_freeze_i;

	// jump view of the current word
	assign is_jump  = (if_insn_i.jmp.opc == `FETCH_JUMP_OPC);
	// sign extend, times four
	assign jump_off = {{4{if_insn_i.jmp.disp[25]}}, if_insn_i.jmp.disp, 2'b00};

	////////////////////
	// next address on acceptance
	////////////////////
	always_comb begin
		if (refetch_q || icpu_err_i) begin
			// same word again
			pc_next = pc_q;
		end else if (is_jump) begin
			pc_next = if_pc_i + jump_off;
		end else begin
			pc_next = if_pc_i + 32'd4;
		end
	end

	////////////////////
	// counter, strobe and refetch flag
	////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc_q      <= `FETCH_RESET_VEC;
			stb_q     <= 1'b1;
			refetch_q <= 1'b0;
		end else if (if_flushpipe_i) begin
			// redirect wins over everything
			pc_q      <= flush_target_i;
			stb_q     <= 1'b1;
			refetch_q <= 1'b0;
		end else if (accept) begin
			pc_q      <= pc_next;
			stb_q     <= 1'b1;
			refetch_q <= 1'b0;
		end else begin
			// second answer while a word is held
			if (genpc_refetch_i)
				refetch_q <= 1'b1;
			// answer arrived under freeze, request served
			if (!if_stall_i)
				stb_q <= 1'b0;
		end
	end

	assign req_adr_o = pc_q;
	assign req_stb_o = stb_q;

	// flush targets and jump arithmetic keep word alignment
	a_req_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
		req_stb_o |-> (req_adr_o[1:0] == 2'b00));

endmodule

// ==== fetch/fetch_if_stage.sv ====
// instruction fetch stage
// save registers for a frozen pipeline, NOP insertion,
// fault tag decode into three exception outputs
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_if_stage (
	input  logic             clk,
	input  logic             rst_n_i,
	input  fetch_pkg::insn_t icpu_dat_i,
	input  logic             icpu_ack_i,
	input  logic             icpu_err_i,
	input  logic [31:0]      icpu_adr_i,
	input  logic [3:0]       icpu_tag_i,
	input  logic             if_freeze_i,
	input  logic             if_flushpipe_i,
	input  logic             no_more_dslot_i,
	input  logic             rfe_i,
	output fetch_pkg::insn_t if_insn_o,
	output logic [31:0]      if_pc_o,
	output logic             if_stall_o,
	output logic             saving_if_insn_o,
	output logic             genpc_refetch_o,
	output logic             except_itlbmiss_o,
	output logic             except_immufault_o,
	output logic             except_ibuserr_o
);
	import fetch_pkg::*;

	insn_t       nop_insn;
	insn_t       insn_saved_q;
	logic [31:0] addr_saved_q;
	logic [2:0]  err_saved_q;
	logic        saved_q;
	logic        save_insn;
	logic [2:0]  err_live;
	logic [2:0]  err_sel;

	// NOP built through the jump view
	always_comb begin
		nop_insn.jmp.opc  = `FETCH_NOP_OPC;
		nop_insn.jmp.disp = `FETCH_NOP_IMM;
	end

	// arrival under freeze with nothing held yet
	assign save_insn        = (icpu_ack_i || icpu_err_i) && if_freeze_i && !saved_q;
	assign saving_if_insn_o = !if_flushpipe_i && save_insn;

	// live tag decode
	// bit 0 tlb miss, bit 1 mmu fault, bit 2 bus error
	assign err_live[0] = icpu_err_i && (icpu_tag_i == `FETCH_ITAG_TE);
	assign err_live[1] = icpu_err_i && (icpu_tag_i == `FETCH_ITAG_PE);
	assign err_live[2] = icpu_err_i && (icpu_tag_i == `FETCH_ITAG_BE);

	////////////////////
	// stage outputs
	////////////////////
	always_comb begin
		if (no_more_dslot_i || rfe_i)
			if_insn_o = nop_insn;
		else if (saved_q)
			if_insn_o = insn_saved_q;
		else if (icpu_ack_i)
			if_insn_o = icpu_dat_i;
		else
			// empty slot or error answer
			if_insn_o = nop_insn;
	end

	assign if_pc_o         = saved_q ? addr_saved_q : {icpu_adr_i[31:2], 2'b00};
	assign if_stall_o      = !icpu_err_i && !icpu_ack_i && !saved_q;
	// another answer showed up on top of a held one
	assign genpc_refetch_o = saved_q && icpu_ack_i;

	// held bits take over from the live tag
	assign err_sel = no_more_dslot_i ? 3'b000 : (saved_q ? err_saved_q : err_live);

	assign except_itlbmiss_o  = err_sel[0];
	assign except_immufault_o = err_sel[1];
	assign except_ibuserr_o   = err_sel[2];

	////////////////////
	// saved flag and error bits
	////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			saved_q     <= 1'b0;
			err_saved_q <= 3'b000;
		end else if (if_flushpipe_i) begin
			saved_q     <= 1'b0;
			err_saved_q <= 3'b000;
		end else if (save_insn) begin
			saved_q     <= 1'b1;
			err_saved_q <= err_live;
		end else if (!if_freeze_i) begin
			// released, held word consumed
			saved_q     <= 1'b0;
			err_saved_q <= 3'b000;
		end
	end

	// held word and its address
	always_ff @(posedge clk) begin
		if (save_insn) begin
			insn_saved_q <= icpu_err_i ? nop_insn : icpu_dat_i;
			addr_saved_q <= {icpu_adr_i[31:2], 2'b00};
		end
	end

	// frozen arrival is held on the next edge
	a_save_sets: assert property (@(posedge clk) disable iff (!rst_n_i)
		(!if_flushpipe_i && save_insn) |=> saved_q);

	// flush drops the held word
	a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n_i)
		if_flushpipe_i |=> !saved_q);

	// no exceptions out of a squashed slot
	a_dslot_mask: assert property (@(posedge clk) disable iff (!rst_n_i)
		no_more_dslot_i |-> !(except_itlbmiss_o || except_immufault_o || except_ibuserr_o));

endmodule

// ==== rtl/fetch_top.sv ====
// fetch subsystem top level
// address generator, instruction memory and fetch stage
`timescale 1ns/1ps

module fetch_top (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             load_we_i,
	input  logic [31:0]      load_adr_i,
	input  logic [31:0]      load_dat_i,
	input  logic             if_freeze_i,
	input  logic             if_flushpipe_i,
	input  logic [31:0]      flush_target_i,
	input  logic             no_more_dslot_i,
	input  logic             rfe_i,
	output fetch_pkg::insn_t if_insn_o,
	output logic [31:0]      if_pc_o,
	output logic             if_stall_o,
	output logic             saving_if_insn_o,
	output logic             except_itlbmiss_o,
	output logic             except_immufault_o,
	output logic             except_ibuserr_o
);
	import fetch_pkg::*;

	// request side
	logic [31:0] req_adr;
	logic        req_stb;
	// answer side
	insn_t       icpu_dat;
	logic        icpu_ack;
	logic        icpu_err;
	logic [31:0] icpu_adr;
	logic [3:0]  icpu_tag;
	// stage back to generator
	logic        genpc_refetch;

	fetch_genpc u_genpc (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.if_freeze_i     (if_freeze_i),
		.if_flushpipe_i  (if_flushpipe_i),
		.flush_target_i  (flush_target_i),
		.if_insn_i       (if_insn_o),
		.if_pc_i         (if_pc_o),
		.if_stall_i      (if_stall_o),
		.genpc_refetch_i (genpc_refetch),
		.icpu_err_i      (icpu_err),
		.req_adr_o       (req_adr),
		.req_stb_o       (req_stb)
	);

	insn_mem u_mem (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.load_we_i  (load_we_i),
		.load_adr_i (load_adr_i),
		.load_dat_i (load_dat_i),
		.req_adr_i  (req_adr),
		.req_stb_i  (req_stb),
		.flush_i    (if_flushpipe_i),
		.icpu_dat_o (icpu_dat),
		.icpu_ack_o (icpu_ack),
		.icpu_err_o (icpu_err),
		.icpu_adr_o (icpu_adr),
		.icpu_tag_o (icpu_tag)
	);

	fetch_if_stage u_if (
		.clk                (clk),
		.rst_n_i            (rst_n_i),
		.icpu_dat_i         (icpu_dat),
		.icpu_ack_i         (icpu_ack),
		.icpu_err_i         (icpu_err),
		.icpu_adr_i         (icpu_adr),
		.icpu_tag_i         (icpu_tag),
		.if_freeze_i        (if_freeze_i),
		.if_flushpipe_i     (if_flushpipe_i),
		.no_more_dslot_i    (no_more_dslot_i),
		.rfe_i              (rfe_i),
		.if_insn_o          (if_insn_o),
		.if_pc_o            (if_pc_o),
		.if_stall_o         (if_stall_o),
		.saving_if_insn_o   (saving_if_insn_o),
		.genpc_refetch_o    (genpc_refetch),
		.except_itlbmiss_o  (except_itlbmiss_o),
		.except_immufault_o (except_immufault_o),
		.except_ibuserr_o   (except_ibuserr_o)
	);

endmodule

// ==== rtl/insn_mem.sv ====
// instruction memory in place of the instruction cache
// load port, fixed-latency answer, fault regions d, c and b
`timescale 1ns/1ps
`include "fetch_defines.svh"

module insn_mem (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             load_we_i,
	input  logic [31:0]      load_adr_i,
	input  logic [31:0]      load_dat_i,
	input  logic [31:0]      req_adr_i,
	input  logic             req_stb_i,
	input  logic             flush_i,
	output fetch_pkg::insn_t icpu_dat_o,
	output logic             icpu_ack_o,
	output logic             icpu_err_o,
	output logic [31:0]      icpu_adr_o,
	output logic [3:0]       icpu_tag_o
);
	import fetch_pkg::*;

	localparam int IDX_W = $clog2(`FETCH_MEM_WORDS);
	localparam int CNT_W = $clog2(`FETCH_MEM_LAT + 1);

	insn_t             mem [`FETCH_MEM_WORDS];
	insn_t             dat_q;
	logic [31:0]       adr_q;
	logic              busy_q;
	logic              rsp_q;
	logic [CNT_W-1:0]  cnt_q;
	logic              fault;

	// word writes from the load port
	always_ff @(posedge clk) begin
		if (load_we_i)
			mem[load_adr_i[IDX_W+1:2]].raw <= load_dat_i;
	end

	////////////////////
	// request tracking
	////////////////////
	// idle, sample, count, answer for one cycle, idle again
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			rsp_q  <= 1'b0;
			cnt_q  <= '0;
		end else if (flush_i) begin
			// pending answer dropped
			busy_q <= 1'b0;
			rsp_q  <= 1'b0;
			cnt_q  <= '0;
		end else if (!busy_q) begin
			if (req_stb_i) begin
				busy_q <= 1'b1;
				cnt_q  <= '0;
			end
		end else if (rsp_q) begin
			busy_q <= 1'b0;
			rsp_q  <= 1'b0;
		end else if (cnt_q == CNT_W'(`FETCH_MEM_LAT - 1)) begin
			rsp_q <= 1'b1;
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// request address and read data
	always_ff @(posedge clk) begin
		if (!busy_q && req_stb_i && !flush_i)
			adr_q <= req_adr_i;
		if (busy_q && !rsp_q)
			dat_q <= mem[adr_q[IDX_W+1:2]];
	end

	// upper nibble selects a fault region
	assign fault = (adr_q[31:28] == `FETCH_ITAG_TE) ||
		(adr_q[31:28] == `FETCH_ITAG_PE) ||
		(adr_q[31:28] == `FETCH_ITAG_BE);

	assign icpu_dat_o = dat_q;
	assign icpu_ack_o = rsp_q && !fault;
	assign icpu_err_o = rsp_q && fault;
	assign icpu_adr_o = adr_q;
	assign icpu_tag_o = icpu_err_o ? adr_q[31:28] : 4'h0;

	// one kind of answer at a time
	a_ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(icpu_ack_o && icpu_err_o));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build the fetch testbench with Verilator and run it
# pass only when the simulation prints its pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module fetch_tb -f sources.f \
	&& ./obj_dir/Vfetch_tb | tee /dev/stderr | grep -x "Simulation passed" > /dev/null \
	&& echo "run.sh: PASS" \
	|| { echo "run.sh: FAIL"; exit 1; }

// ==== sources.f ====
+incdir+common
common/fetch_pkg.sv
fetch/fetch_genpc.sv
fetch/fetch_if_stage.sv
rtl/insn_mem.sv
rtl/fetch_top.sv
tests/fetch_tb.sv

// ==== tests/fetch_tb.sv ====
// testbench for the fetch subsystem
// clock, reset, cycle limit, typed compare tasks, memory model and load port,
// directed tests for sequential fetch, freeze, flush, jumps, fault tags and rfe
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_tb;
	import fetch_pkg::*;

	// memory fill takes about 260 cycles, the six tests about 400
	localparam int MAX_CYCLES = 2000;
	localparam int MEM_IDX_W  = $clog2(`FETCH_MEM_WORDS);

	logic        clk;
	logic        rst_n_i;
	logic        load_we_i;
	logic [31:0] load_adr_i;
	logic [31:0] load_dat_i;
	logic        if_freeze_i;
	logic        if_flushpipe_i;
	logic [31:0] flush_target_i;
	logic        no_more_dslot_i;
	logic        rfe_i;
	insn_t       if_insn_o;
	logic [31:0] if_pc_o;
	logic        if_stall_o;
	logic        saving_if_insn_o;
	logic        except_itlbmiss_o;
	logic        except_immufault_o;
	logic        except_ibuserr_o;

	// expected memory contents with one entry per word
	insn_t  model [`FETCH_MEM_WORDS];
	insn_t  nop_word;
	integer seed;
	int     cycles = 0;

	fetch_top dut (
		.clk                (clk),
		.rst_n_i            (rst_n_i),
		.load_we_i          (load_we_i),
		.load_adr_i         (load_adr_i),
		.load_dat_i         (load_dat_i),
		.if_freeze_i        (if_freeze_i),
		.if_flushpipe_i     (if_flushpipe_i),
		.flush_target_i     (flush_target_i),
		.no_more_dslot_i    (no_more_dslot_i),
		.rfe_i              (rfe_i),
		.if_insn_o          (if_insn_o),
		.if_pc_o            (if_pc_o),
		.if_stall_o         (if_stall_o),
		.saving_if_insn_o   (saving_if_insn_o),
		.except_itlbmiss_o  (except_itlbmiss_o),
		.except_immufault_o (except_immufault_o),
		.except_ibuserr_o   (except_ibuserr_o)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
			stop_run($sformatf("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES));
	end

	////////////////////
	// failure and compares
	////////////////////
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_insn(input string what, input insn_t got, input insn_t exp);
		if (got !== exp)
			stop_run($sformatf("Error at %0d ns: %s is %h, expected %h",
				$time, what, got.raw, exp.raw));
	endtask

	task automatic check_adr(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_run($sformatf("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp));
	endtask

	////////////////////
	// word builders and model lookup
	////////////////////
	// pattern from the whole word index and an opcode that is never zero
	function automatic insn_t fill_word(input int idx);
		insn_t w;
		w.raw = {4'h9, idx[7:0], 4'h6, ~idx[7:0], idx[7:0]};
		return w;
	endfunction

	function automatic insn_t rand_word();
		insn_t w;
		w.raw = $random(seed);
		// keep it off the jump opcode
		if (w.jmp.opc == `FETCH_JUMP_OPC)
			w.jmp.opc = 6'h2a;
		return w;
	endfunction

	function automatic insn_t jump_word(input int disp);
		insn_t w;
		w.jmp.opc  = `FETCH_JUMP_OPC;
		w.jmp.disp = 26'(disp);
		return w;
	endfunction

	// displacement counts words
	function automatic logic [31:0] jump_dest(input logic [31:0] pc, input int disp);
		return pc + 32'(disp * 4);
	endfunction

	function automatic insn_t model_at(input logic [31:0] adr);
		return model[adr[MEM_IDX_W+1:2]];
	endfunction

	////////////////////
	// drive and wait helpers
	////////////////////
	task automatic after_edge();
		@(posedge clk);
		#1;
	endtask

	task automatic load_word(input logic [31:0] adr, input insn_t w);
		after_edge();
		load_we_i  = 1'b1;
		load_adr_i = adr;
		load_dat_i = w.raw;
		model[adr[MEM_IDX_W+1:2]] = w;
	endtask

	task automatic finish_loads();
		after_edge();
		load_we_i = 1'b0;
	endtask

	// mid-cycle sample of the next presented word
	task automatic wait_word(output insn_t insn, output logic [31:0] pc);
		@(negedge clk);
		while (if_stall_o)
			@(negedge clk);
		insn = if_insn_o;
		pc   = if_pc_o;
	endtask

	// freeze until a word is held and the memory idles
	task automatic park();
		after_edge();
		if_freeze_i = 1'b1;
		@(negedge clk);
		while (!saving_if_insn_o)
			@(negedge clk);
		after_edge();
		after_edge();
	endtask

	// flush under freeze and then freeze as asked
	task automatic restart_at(input logic [31:0] target, input logic frozen);
		after_edge();
		if_flushpipe_i = 1'b1;
		flush_target_i = target;
		after_edge();
		if_flushpipe_i = 1'b0;
		if_freeze_i    = frozen;
	endtask

	task automatic fill_memory();
		int i;
		park();
		for (i = 0; i < `FETCH_MEM_WORDS; i++)
			load_word(32'(i * 4), fill_word(i));
		finish_loads();
		restart_at(`FETCH_RESET_VEC, 1'b0);
	endtask

	////////////////////
	// directed tests
	////////////////////
	task automatic sequential_fetch();
		insn_t       insn;
		logic [31:0] pc;
		int          k;
		park();
		for (k = 0; k < 8; k++)
			load_word(`FETCH_RESET_VEC + 32'(4 * k), rand_word());
		finish_loads();
		restart_at(`FETCH_RESET_VEC, 1'b0);
		for (k = 0; k < 8; k++) begin
			wait_word(insn, pc);
			check_adr("sequential pc", pc, `FETCH_RESET_VEC + 32'(4 * k));
			check_insn("sequential word", insn, model_at(`FETCH_RESET_VEC + 32'(4 * k)));
		end
	endtask

	task automatic freeze_save();
		insn_t       insn;
		logic [31:0] pc;
		logic [31:0] base;
		int          saves;
		base  = 32'h0000_0200;
		saves = 0;
		park();
		load_word(base, rand_word());
		load_word(base + 32'd4, rand_word());
		finish_loads();
		// request pending while frozen
		restart_at(base, 1'b1);
		repeat (10) begin
			@(negedge clk);
			if (saving_if_insn_o)
				saves++;
			if (saves > 0) begin
				check_bit("held stall", if_stall_o, 1'b0);
				check_insn("held word", if_insn_o, model_at(base));
				check_adr("held pc", if_pc_o, base);
			end
		end
		check_bit("single save pulse", saves == 1, 1'b1);
		after_edge();
		if_freeze_i = 1'b0;
		// held word consumed once and then the next address
		wait_word(insn, pc);
		check_adr("release pc", pc, base);
		check_insn("release word", insn, model_at(base));
		wait_word(insn, pc);
		check_adr("post release pc", pc, base + 32'd4);
		check_insn("post release word", insn, model_at(base + 32'd4));
	endtask

	task automatic flush_discard();
		insn_t       insn;
		logic [31:0] pc;
		logic [31:0] target;
		target = 32'h0000_0300;
		park();
		// held word dropped and a fresh request left pending under freeze
		restart_at(32'h0000_0280, 1'b1);
		after_edge();
		while (if_stall_o)
			after_edge();
		// flush lands on the arrival cycle
		if_flushpipe_i = 1'b1;
		flush_target_i = target;
		@(negedge clk);
		check_bit("save during flush", saving_if_insn_o, 1'b0);
		after_edge();
		if_flushpipe_i = 1'b0;
		if_freeze_i    = 1'b0;
		@(negedge clk);
		check_bit("stall after flush", if_stall_o, 1'b1);
		wait_word(insn, pc);
		check_adr("flush target pc", pc, target);
		check_insn("flush target word", insn, model_at(target));
	endtask

	task automatic jump_follow();
		insn_t       insn;
		logic [31:0] pc;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		a = 32'h0000_0140;
		b = jump_dest(a, 5);
		c = jump_dest(b, -9);
		park();
		load_word(a, jump_word(5));
		load_word(b, jump_word(-9));
		load_word(c, rand_word());
		finish_loads();
		restart_at(a, 1'b0);
		wait_word(insn, pc);
		check_adr("forward jump pc", pc, a);
		check_insn("forward jump word", insn, model_at(a));
		wait_word(insn, pc);
		check_adr("backward jump pc", pc, b);
		check_insn("backward jump word", insn, model_at(b));
		wait_word(insn, pc);
		check_adr("jump landing pc", pc, c);
		check_insn("jump landing word", insn, model_at(c));
		wait_word(insn, pc);
		check_adr("after landing pc", pc, c + 32'd4);
		check_insn("after landing word", insn, model_at(c + 32'd4));
	endtask

	task automatic fault_tags();
		insn_t       insn;
		logic [31:0] pc;
		logic [31:0] target;
		logic [3:0]  tags [3];
		int          i;
		tags[0] = `FETCH_ITAG_TE;
		tags[1] = `FETCH_ITAG_PE;
		tags[2] = `FETCH_ITAG_BE;
		for (i = 0; i < 3; i++) begin
			target = {tags[i], 28'h000_0100};
			park();
			restart_at(target, 1'b0);
			wait_word(insn, pc);
			check_adr("fault pc", pc, target);
			check_insn("fault word", insn, nop_word);
			check_bit("tlb miss", except_itlbmiss_o, tags[i] == `FETCH_ITAG_TE);
			check_bit("mmu fault", except_immufault_o, tags[i] == `FETCH_ITAG_PE);
			check_bit("bus error", except_ibuserr_o, tags[i] == `FETCH_ITAG_BE);
			// same fault in a squashed slot
			park();
			no_more_dslot_i = 1'b1;
			restart_at(target, 1'b0);
			wait_word(insn, pc);
			check_insn("squashed fault word", insn, nop_word);
			check_bit("squashed tlb miss", except_itlbmiss_o, 1'b0);
			check_bit("squashed mmu fault", except_immufault_o, 1'b0);
			check_bit("squashed bus error", except_ibuserr_o, 1'b0);
			after_edge();
			no_more_dslot_i = 1'b0;
		end
	endtask

	task automatic rfe_suppress();
		insn_t       insn;
		logic [31:0] pc;
		logic [31:0] base;
		int          k;
		base = 32'h0000_0180;
		park();
		rfe_i = 1'b1;
		restart_at(base, 1'b0);
		for (k = 0; k < 3; k++) begin
			wait_word(insn, pc);
			check_adr("rfe pc", pc, base + 32'(4 * k));
			check_insn("rfe word", insn, nop_word);
		end
		after_edge();
		rfe_i = 1'b0;
	endtask

	initial begin
		clk             = 1'b0;
		rst_n_i         = 1'b0;
		load_we_i       = 1'b0;
		load_adr_i      = '0;
		load_dat_i      = '0;
		if_freeze_i     = 1'b0;
		if_flushpipe_i  = 1'b0;
		flush_target_i  = '0;
		no_more_dslot_i = 1'b0;
		rfe_i           = 1'b0;
		seed            = 32;
		nop_word.raw    = {`FETCH_NOP_OPC, `FETCH_NOP_IMM};
		repeat (2) @(posedge clk);
		#1;
		rst_n_i = 1'b1;
		fill_memory();
		sequential_fetch();
		freeze_save();
		flush_discard();
		jump_follow();
		fault_tags();
		rfe_suppress();
		$display("Simulation passed");
		$finish;
	end

endmodule
